// File: Bender.yml
package:
  name: keypad_calc

sources:
  - rtl/calc_pkg.sv
  - rtl/keypad_scanner.sv
  - rtl/key_fifo.sv
  - rtl/calc_engine.sv
  - rtl/calc_top.sv
  - target: test
    files:
      - tests/calc_properties.sv
      - tests/calc_tb.sv

// File: rtl/calc_engine.sv
`timescale 1ns/1ps

module calc_engine (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 tok_valid,
    input  calc_pkg::key_code_t  tok_code,
    output logic                 tok_pop,       // one cycle per token
    output calc_pkg::calc_word_t result,
    output logic                 result_valid   // one-cycle strobe
);
    import calc_pkg::*;

    typedef enum logic [1:0] {
        EN_IDLE,
        EN_MULT,
        EN_REPORT
    } eng_state_t;

    eng_state_t state;
    calc_word_t acc;
    calc_word_t operand;
    calc_op_t   pend_op;
    logic       fresh;        // next digit starts a new number
    calc_op_t   mul_next_op;  // op to store once the multiply ends
    logic       mul_eq;       // multiply was started by equals
    calc_word_t mcand;
    calc_word_t mplier;
    calc_word_t prod;
    logic [$clog2($bits(calc_word_t))-1:0] mul_cnt;

    logic [3:0] digit_val;
    logic       is_digit;
    logic       is_op;
    calc_op_t   tok_op;
    calc_word_t eval_val;     // pending op applied, non-mul
    calc_word_t step_prod;

    assign tok_pop   = (state == EN_IDLE) && tok_valid;
    assign digit_val = DIGIT_VAL[tok_code];
    assign is_digit  = (digit_val != DIGIT_NONE);
    assign is_op     = (tok_code == KEY_ADD) || (tok_code == KEY_SUB) || (tok_code == KEY_MUL);
    assign step_prod = prod + (mplier[0] ? mcand : '0);  // shift-add step

    always_comb begin
        case (tok_code)
            KEY_ADD: tok_op = OP_ADD;
            KEY_SUB: tok_op = OP_SUB;
            default: tok_op = OP_MUL;
        endcase
        case (pend_op)
            OP_LOAD: eval_val = operand;
            OP_ADD:  eval_val = acc + operand;
            OP_SUB:  eval_val = acc - operand;
            default: eval_val = acc;      // mul goes through the multiplier
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= EN_IDLE;
            acc          <= '0;
            operand      <= '0;
            pend_op      <= OP_LOAD;
            fresh        <= 1'b0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                EN_IDLE: begin
                    if (tok_pop) begin
                        if (is_digit) begin
                            operand <= fresh ? calc_word_t'(digit_val)
                                             : (operand << 3) + (operand << 1)
                                               + calc_word_t'(digit_val);
                            fresh   <= 1'b0;
                        end else if (tok_code == KEY_NEG) begin
                            operand <= -operand;        // keep it as the entry
                            fresh   <= 1'b0;
                        end else if (tok_code == KEY_CLR) begin
                            acc     <= '0;
                            operand <= '0;
                            pend_op <= OP_LOAD;
                            fresh   <= 1'b0;
                        end else if (pend_op == OP_MUL) begin
                            mul_next_op <= tok_op;      // op or equals waits
                            mul_eq      <= (tok_code == KEY_EQ);
                            mcand       <= acc;
                            mplier      <= operand;
                            prod        <= '0;
                            mul_cnt     <= '0;
                            state       <= EN_MULT;
                        end else if (is_op) begin
                            acc     <= eval_val;
                            pend_op <= tok_op;
                            operand <= '0;
                            fresh   <= 1'b0;
                        end else begin                  // equals
                            acc   <= eval_val;
                            state <= EN_REPORT;
                        end
                    end
                end
                EN_MULT: begin
                    if (&mul_cnt) begin                 // 16th step
                        acc     <= step_prod;
                        operand <= '0;
                        pend_op <= mul_next_op;
                        fresh   <= 1'b0;
                        state   <= mul_eq ? EN_REPORT : EN_IDLE;
                    end else begin
                        prod    <= step_prod;
                        mcand   <= mcand << 1;
                        mplier  <= mplier >> 1;
                        mul_cnt <= mul_cnt + 1'b1;
                    end
                end
                EN_REPORT: begin
                    result       <= acc;
                    result_valid <= 1'b1;
                    operand      <= acc;                // result carries on
                    pend_op      <= OP_LOAD;
                    fresh        <= 1'b1;
                    state        <= EN_IDLE;
                end
                default: state <= EN_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/calc_pkg.sv
package calc_pkg;

    typedef logic [3:0]  key_code_t;   // row * 4 + column
    typedef logic [15:0] calc_word_t;  // two's complement, wraps mod 2^16

    typedef enum logic [1:0] {
        OP_LOAD,                       // take operand as is
        OP_ADD,
        OP_SUB,
        OP_MUL
    } calc_op_t;

    // operator and function keys
    localparam key_code_t KEY_ADD = 4'd3;
    localparam key_code_t KEY_SUB = 4'd7;
    localparam key_code_t KEY_MUL = 4'd11;
    localparam key_code_t KEY_EQ  = 4'd12;
    localparam key_code_t KEY_CLR = 4'd14;
    localparam key_code_t KEY_NEG = 4'd15;

    localparam logic [3:0] DIGIT_NONE = 4'hF;  // marks a non-digit key

    // key position -> digit value
    localparam logic [3:0] DIGIT_VAL [16] = '{
        4'd1, 4'd2, 4'd3, DIGIT_NONE,
        4'd4, 4'd5, 4'd6, DIGIT_NONE,
        4'd7, 4'd8, 4'd9, DIGIT_NONE,
        DIGIT_NONE, 4'd0, DIGIT_NONE, DIGIT_NONE
    };

    // digit value -> key position
    localparam key_code_t DIGIT_KEY [10] = '{
        4'd13, 4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd6, 4'd8, 4'd9, 4'd10
    };

    localparam int DEBOUNCE_CYCLES = 10;                        // stable cycles per edge
    localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES);   // counter width

    localparam int FIFO_DEPTH = 4;                  // power of two
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH); // pointer width

endpackage

// File: rtl/calc_top.sv
`timescale 1ns/1ps

module calc_top (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic [3:0]           row_in,       // keypad rows, active low
    output logic [3:0]           col_out,      // keypad columns
    output calc_pkg::calc_word_t result,
    output logic                 result_valid
);
    import calc_pkg::*;

    logic      key_req;      // scanner -> fifo request
    logic      key_read;     // fifo -> scanner accept
    key_code_t key_code;
    logic      tok_valid;    // fifo -> engine
    key_code_t tok_code;
    logic      tok_pop;      // engine -> fifo

    keypad_scanner u_scanner (
        .clk      (clk),
        .nRST     (nRST),
        .row_in   (row_in),
        .col_out  (col_out),
        .key_req  (key_req),
        .key_read (key_read),
        .key_code (key_code)
    );

    key_fifo u_fifo (
        .clk       (clk),
        .nRST      (nRST),
        .key_req   (key_req),
        .key_code  (key_code),
        .key_read  (key_read),
        .tok_valid (tok_valid),
        .tok_code  (tok_code),
        .tok_pop   (tok_pop)
    );

    calc_engine u_engine (
        .clk          (clk),
        .nRST         (nRST),
        .tok_valid    (tok_valid),
        .tok_code     (tok_code),
        .tok_pop      (tok_pop),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: rtl/key_fifo.sv
`timescale 1ns/1ps

module key_fifo (
    input  logic                clk,
    input  logic                nRST,
    input  logic                key_req,    // scanner request, held
    input  calc_pkg::key_code_t key_code,
    output logic                key_read,   // one-cycle write strobe
    output logic                tok_valid,  // not empty
    output calc_pkg::key_code_t tok_code,   // oldest entry
    input  logic                tok_pop
);
    import calc_pkg::*;

    key_code_t          mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;       // occupancy 0..FIFO_DEPTH
    logic               full;
    logic               push;
    logic               pop;

    assign full      = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign tok_valid = (count != '0);
    assign tok_code  = mem[rd_ptr];
    assign push      = key_read;              // code is stable while key_req held
    assign pop       = tok_pop && tok_valid;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_read <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else begin
            // ~key_read blocks a second strobe while key_req falls
            key_read <= key_req && !key_read && !full;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;      // wraps, depth is 2^n
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= key_code;
        end
    end

endmodule

// File: rtl/keypad_scanner.sv
`timescale 1ns/1ps

module keypad_scanner (
    input  logic               clk,
    input  logic               nRST,
    input  logic [3:0]         row_in,    // active low, pulled up
    output logic [3:0]         col_out,   // one column low at a time
    output logic               key_req,   // held until key_read
    input  logic               key_read,  // one-cycle accept strobe
    output calc_pkg::key_code_t key_code
);
    import calc_pkg::*;

    typedef enum logic [1:0] {
        ST_SCAN,
        ST_DEBOUNCE,
        ST_REQUEST,
        ST_RELEASE
    } scan_state_t;

    scan_state_t           state;
    logic [1:0]            col_index;   // column currently driven low
    logic [DEBOUNCE_W-1:0] deb_cnt;     // consecutive stable cycles
    logic [1:0]            hit_row;     // row latched at first contact
    logic [1:0]            low_row;     // lowest low row right now
    logic                  any_low;
    logic                  row_held;    // latched row still low
    logic                  deb_done;

    // drive the selected column low
    always_comb begin
        col_out = 4'b1111;
        col_out[col_index] = 1'b0;
    end

    // lowest low row wins, other rows ignored
    always_comb begin
        any_low = ~&row_in;
        low_row = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row_in[r]) begin
                low_row = 2'(r);
            end
        end
    end

    assign row_held = !row_in[hit_row];
    assign deb_done = (deb_cnt == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1));
    assign key_req  = (state == ST_REQUEST);  // drops the cycle after key_read

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= ST_SCAN;
            col_index <= 2'd0;
            deb_cnt   <= '0;
        end else begin
            case (state)
                ST_SCAN: begin
                    if (any_low) begin          // freeze column, start count
                        state   <= ST_DEBOUNCE;
                        deb_cnt <= '0;
                    end else begin
                        col_index <= col_index + 2'd1;
                    end
                end
                ST_DEBOUNCE: begin
                    if (!row_held) begin        // bounce, back to scanning
                        state <= ST_SCAN;
                    end else if (deb_done) begin
                        state <= ST_REQUEST;
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
                ST_REQUEST: begin
                    if (key_read) begin         // token taken
                        state   <= ST_RELEASE;
                        deb_cnt <= '0;
                    end
                end
                ST_RELEASE: begin
                    if (any_low) begin
                        deb_cnt <= '0;          // still held or bouncing
                    end else if (deb_done) begin
                        state     <= ST_SCAN;
                        col_index <= col_index + 2'd1;  // resume at next column
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
                default: state <= ST_SCAN;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (state == ST_SCAN && any_low) begin
            hit_row <= low_row;
        end
        if (state == ST_DEBOUNCE && row_held && deb_done) begin
            key_code <= {hit_row, col_index};   // row * 4 + col
        end
    end

endmodule

// File: sim.f
rtl/calc_pkg.sv
rtl/keypad_scanner.sv
rtl/key_fifo.sv
rtl/calc_engine.sv
rtl/calc_top.sv
tests/calc_properties.sv
tests/calc_tb.sv

// File: tests/calc_properties.sv
`timescale 1ns/1ps

module calc_properties (
    input logic                clk,
    input logic                nRST,
    input logic                key_req,
    input calc_pkg::key_code_t key_code,
    input logic                key_read,
    input logic                tok_valid,
    input logic                tok_pop,
    input logic [3:0]          col_out,
    input logic                result_valid
);
    int unsigned fail_count = 0;    // read by the testbench at the end

    // request and code held until accepted
    req_held: assert property (@(posedge clk) disable iff (!nRST)
        key_req && !key_read |=> key_req && $stable(key_code))
        else begin
            fail_count++;
            $error("key request dropped or its code changed before key_read");
        end

    read_single: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !key_read)
        else begin
            fail_count++;
            $error("key_read high in two consecutive cycles");
        end

    pop_valid: assert property (@(posedge clk) disable iff (!nRST)
        tok_pop |-> tok_valid)
        else begin
            fail_count++;
            $error("token popped from an empty FIFO");
        end

    one_column: assert property (@(posedge clk) disable iff (!nRST)
        $onehot(~col_out))
        else begin
            fail_count++;
            $error("col_out does not have exactly one low bit");
        end

    result_pulse: assert property (@(posedge clk) disable iff (!nRST)
        result_valid |=> !result_valid)
        else begin
            fail_count++;
            $error("result_valid lasted more than one cycle");
        end

endmodule

bind calc_top calc_properties u_props (
    .clk          (clk),
    .nRST         (nRST),
    .key_req      (key_req),
    .key_code     (key_code),
    .key_read     (key_read),
    .tok_valid    (tok_valid),
    .tok_pop      (tok_pop),
    .col_out      (col_out),
    .result_valid (result_valid)
);

// File: tests/calc_tb.sv
`timescale 1ns/1ps

module calc_tb;
    import calc_pkg::*;

    localparam int HOLD_CYCLES  = 3 * DEBOUNCE_CYCLES + 8;  // key down, then key up
    localparam int SHORT_CYCLES = DEBOUNCE_CYCLES / 2;      // too short to register
    localparam int WAIT_LIMIT   = 400;                      // cycles per wait loop

    logic        clk;
    logic        nRST;
    logic [3:0]  row_in;
    logic [3:0]  col_out;
    calc_word_t  result;
    logic        result_valid;

    logic        pressed;          // keypad model, a key is down
    key_code_t   press_code;       // which key
    calc_word_t  results [$];      // captured result strobes
    logic [31:0] lfsr_state;
    int          checks;
    int          value_errors;
    int          timeouts;

    calc_top DUT (
        .clk          (clk),
        .nRST         (nRST),
        .row_in       (row_in),
        .col_out      (col_out),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    // row of the held key goes low only while its column is driven
    always @(negedge clk) begin
        if (pressed && !col_out[press_code[1:0]]) begin
            row_in <= ~(4'b0001 << press_code[3:2]);
        end else begin
            row_in <= 4'b1111;      // pull-ups
        end
    end

    always @(negedge clk) begin
        if (result_valid) begin
            results.push_back(result);  // one entry per strobe
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    // keypad layout: 1-9 in three rows of three, 0 under 8
    function automatic key_code_t digit_key(input int d);
        if (d == 0) begin
            return 4'd13;
        end
        return key_code_t'(((d - 1) / 3) * 4 + (d - 1) % 3);
    endfunction

    task automatic press_key(input key_code_t code, input int hold);
        logic found;
        found = 1'b0;
        @(negedge clk);
        press_code <= code;
        pressed    <= 1'b1;
        for (int i = 0; i < WAIT_LIMIT && !found; i++) begin
            @(posedge clk);
            found = !row_in[code[3:2]];   // column reached
        end
        if (!found) begin
            timeouts++;
            $display("timeout: the scan never reached the column of key %0d", code);
        end
        repeat (hold) @(negedge clk);
        pressed <= 1'b0;
        repeat (hold) @(negedge clk);     // release time
    endtask

    task automatic tap_key(input key_code_t code);
        press_key(code, HOLD_CYCLES);
    endtask

    task automatic enter_number(input int unsigned value);
        if (value >= 100) begin
            tap_key(digit_key(value / 100));
        end
        if (value >= 10) begin
            tap_key(digit_key((value / 10) % 10));
        end
        tap_key(digit_key(value % 10));
    endtask

    task automatic expect_result(input string name, input calc_word_t expected);
        calc_word_t got;
        for (int i = 0; i < WAIT_LIMIT && results.size() == 0; i++) begin
            @(negedge clk);
        end
        if (results.size() == 0) begin
            timeouts++;
            $display("timeout: no result appeared in test %s", name);
        end else begin
            got = results.pop_front();
            checks++;
            assert (got == expected) else begin
                value_errors++;
                $display("[ERROR] %s: expected %0d, actual %0d", name, expected, got);
            end
        end
    endtask

    task automatic addition_sequence();
        tap_key(KEY_CLR);
        enter_number(12);
        tap_key(KEY_ADD);
        enter_number(34);
        tap_key(KEY_EQ);
        expect_result("addition", 16'd46);
    endtask

    task automatic chained_ops();
        enter_number(7);            // fresh entry after the last result
        tap_key(KEY_MUL);
        enter_number(8);
        tap_key(KEY_SUB);           // 56 pending minus
        enter_number(6);
        tap_key(KEY_EQ);
        expect_result("chain", 16'd50);
        enter_number(300);
        tap_key(KEY_MUL);
        enter_number(300);
        tap_key(KEY_EQ);
        expect_result("wrap multiply", 16'd24464);  // 90000 mod 2^16
    endtask

    task automatic negate_and_clear();
        enter_number(5);
        tap_key(KEY_NEG);
        tap_key(KEY_ADD);
        enter_number(2);
        tap_key(KEY_EQ);
        expect_result("negate", 16'd65533);
        tap_key(KEY_ADD);           // continue from -3
        enter_number(4);
        tap_key(KEY_EQ);
        expect_result("continue", 16'd1);
        enter_number(9);            // must not become 19
        tap_key(KEY_EQ);
        expect_result("fresh entry", 16'd9);
        tap_key(KEY_CLR);
        tap_key(KEY_EQ);
        expect_result("clear", 16'd0);
    endtask

    task automatic bounce_rejection();
        tap_key(KEY_CLR);
        press_key(4'd9, SHORT_CYCLES);   // released before debounce ends
        tap_key(KEY_EQ);
        expect_result("bounce", 16'd0);
    endtask

    task automatic random_rounds();
        int unsigned a;
        int unsigned b;
        int unsigned op;
        calc_word_t  expected;
        key_code_t   op_key;
        for (int r = 0; r < 5; r++) begin
            a  = take_bits(10) % 1000;
            b  = take_bits(10) % 1000;
            op = take_bits(2) % 3;
            case (op)
                0: begin
                    op_key   = KEY_ADD;
                    expected = calc_word_t'(a + b);
                end
                1: begin
                    op_key   = KEY_SUB;
                    expected = calc_word_t'(a - b);   // wraps below zero
                end
                default: begin
                    op_key   = KEY_MUL;
                    expected = calc_word_t'(a * b);
                end
            endcase
            tap_key(KEY_CLR);
            enter_number(a);
            tap_key(op_key);
            enter_number(b);
            tap_key(KEY_EQ);
            expect_result($sformatf("random round %0d", r), expected);
        end
    endtask

    initial begin
        nRST         = 1'b0;
        row_in       = 4'b1111;
        pressed      = 1'b0;
        press_code   = '0;
        lfsr_state   = 32'h35fd8bdb;
        checks       = 0;
        value_errors = 0;
        timeouts     = 0;
        repeat (3) @(negedge clk);
        nRST = 1'b1;
        addition_sequence();
        chained_ops();
        negate_and_clear();
        bounce_rejection();
        random_rounds();
        $display("%0d checks, %0d value errors, %0d timeouts, %0d assertion failures",
                 checks, value_errors, timeouts, DUT.u_props.fail_count);
        if (value_errors == 0 && timeouts == 0 && DUT.u_props.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
